/* test/loader_stim.txt */
# columns, all hex: acc img page flash_addr
# acc 2 = boot (page column unused), 3 = page read
# flash_addr = {2'b00, img, page or 805, 7'b0}
2 3 123 1c0280
3 3 123 189180
3 3 fff 1fff80
3 0 000 000000
2 5 000 2c0280
3 5 7a1 2bd080
3 7 456 3a2b00
2 1 03c 0c0280
3 1 02a 081500
3 2 800 140000

/* sources.f */
common/bubble_pkg.sv
verilog/load_sequencer.sv
spi/spi_bit_engine.sv
mask/loop_mask_table.sv
verilog/outbuf_writer.sv
verilog/spi_loader_top.sv
test/spi_loader_props.sv
test/spi_loader_tb.sv

/* Bender.yml */
package:
  name: spi_loader

sources:
  - common/bubble_pkg.sv
  - verilog/load_sequencer.sv
  - spi/spi_bit_engine.sv
  - mask/loop_mask_table.sv
  - verilog/outbuf_writer.sv
  - verilog/spi_loader_top.sv
  - target: test
    files:
      - test/spi_loader_props.sv
      - test/spi_loader_tb.sv

/* test/spi_loader_tb.sv */
`timescale 1ns/1ps

module spi_loader_tb
    import bubble_pkg::*;
();

    localparam int BOOT_BITS = 40;
    localparam int MAP_BITS  = 64;
    localparam int PAGE_GOOD = 30;
    localparam int LEAD_BITS = 6;
    localparam int SW        = BOOT_BITS + MAP_BITS;   // longest stream of one access
    localparam int CLK_P     = 4;
    localparam int HOLD      = 8;                      // cycles acc stays up after busy falls
    localparam logic [31:0] SEED = 32'd66621;

    logic       MCLK  = 1'b0;
    logic       rst_n = 1'b0;
    logic [2:0] img   = '0;
    acc_kind_e  acc   = acc_none;
    page_t      page  = '0;
    logic       miso  = 1'b0;
    logic       busy;
    logic       buf_we;
    buf_addr_t  buf_addr;
    logic       buf_data;
    logic       ncs;
    logic       sclk;
    logic       mosi;

    logic [1:0]  q_acc  [$];    // one entry per stim line
    logic [2:0]  q_img  [$];
    page_t       q_page [$];
    flash_addr_t q_addr [$];
    int          n_lines;
    logic        stim_loaded = 1'b0;

    logic [SW-1:0] flash_bits;  // flash contents behind the last command
    logic [31:0]   rx_word;
    int            rx_cnt   = 0;
    int            data_cnt = 0;
    logic          sclk_q   = 1'b1;
    logic          cmd_seen = 1'b0;

    logic          buf_ref [0:32767];   // bubble buffer as seen on the write port
    int            wr_cnt = 0;
    logic          map_ref [0:4095];    // loop map in table order
    logic          map_loaded = 1'b0;
    logic [SW-1:0] exp_bits;

    always #(CLK_P / 2) MCLK = ~MCLK;

    spi_loader_top #(
        .BOOT_BITS(BOOT_BITS), .MAP_BITS(MAP_BITS),
        .PAGE_GOOD(PAGE_GOOD), .LEAD_BITS(LEAD_BITS)
    ) UUT (
        .MCLK(MCLK), .rst_n(rst_n), .img(img), .acc(acc), .page(page), .busy(busy),
        .buf_we(buf_we), .buf_addr(buf_addr), .buf_data(buf_data),
        .ncs(ncs), .sclk(sclk), .mosi(mosi), .miso(miso)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    // bit stream stored at a flash address, map region leans towards good loops
    function automatic logic [SW-1:0] flash_stream(input flash_addr_t a);
        logic [31:0]   st;
        logic [SW-1:0] s;
        st = SEED ^ {8'h00, a};    // reseed per address
        for (int k = 0; k < SW; k++)
        begin
            st   = lcg_next(st);
            s[k] = st[16];
            if (k >= BOOT_BITS)
            begin
                st   = lcg_next(st);
                s[k] = s[k] | st[16];  // about 3 in 4 good
            end
        end
        return s;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("t=%0t %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "stopped after failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    task automatic clear_region(input int base, input int len);
        for (int k = 0; k < len; k++)
            buf_ref[base + k] = 1'bx;      // stale data must not pass
    endtask

    // boot and map bits back to back from BOOT_BASE
    task automatic check_boot();
        map_addr_t ma;
        for (int k = 0; k < SW; k++)
            check_value($sformatf("buf[%0d]", BOOT_BASE + k), buf_ref[BOOT_BASE + k],
                        exp_bits[k]);
        check_value("buffer writes", wr_cnt, SW);
        check_value("flash data bits", data_cnt, SW);
        for (int j = 0; j < MAP_BITS; j++)
        begin
            ma = map_addr_t'(j);
            map_ref[{ma[11:4], ~ma[3:0]}] = exp_bits[BOOT_BITS + j];  // low nibble inverted
        end
        map_loaded = 1'b1;
    endtask

    // walk the map from slot 0 until PAGE_GOOD good loops are placed
    task automatic check_page();
        int   s;
        int   goods;
        int   nflash;
        logic want;
        s      = 0;
        goods  = 0;
        nflash = 0;
        while (goods < PAGE_GOOD)
        begin
            assert (map_loaded && s < MAP_BITS)
            else report_failure("page walk needs map entries that no boot access loaded");
            if (map_ref[s] === 1'b0)
                want = 1'b0;               // bad loop
            else if (goods < LEAD_BITS)
            begin
                want  = 1'b1;              // lead loop, no flash bit
                goods = goods + 1;
            end
            else
            begin
                want   = exp_bits[nflash];
                nflash = nflash + 1;
                goods  = goods + 1;
            end
            check_value($sformatf("buf[%0d]", PAGE_BASE + s), buf_ref[PAGE_BASE + s], want);
            s = s + 1;
        end
        check_value("buffer writes", wr_cnt, s);
        check_value("flash data bits", data_cnt, nflash);
    endtask

    task automatic run_access(input int i);
        acc_kind_e   k;
        flash_addr_t ea;
        k        = acc_kind_e'(q_acc[i]);
        ea       = q_addr[i];
        exp_bits = flash_stream(ea);
        if (k == acc_boot)
            clear_region(BOOT_BASE, SW);
        else
            clear_region(PAGE_BASE, MAP_BITS);
        cmd_seen = 1'b0;
        wr_cnt   = 0;
        @(posedge MCLK);
        acc  <= k;
        img  <= q_img[i];
        page <= q_page[i];
        @(negedge MCLK);
        while (busy !== 1'b1)              // watchdog bounds both waits
            @(negedge MCLK);
        while (busy !== 1'b0)
            @(negedge MCLK);
        check_value("ncs", ncs, 1);
        repeat (HOLD)
        begin
            @(negedge MCLK);
            check_value("busy with acc held", busy, 0);
        end
        assert (cmd_seen) else report_failure("flash saw no complete read command");
        check_value("cmd opcode", rx_word[31:24], OPC_READ);
        check_value("cmd address", rx_word[23:0], ea);
        if (k == acc_boot)
            check_boot();
        else
            check_page();
        @(posedge MCLK);
        acc <= acc_none;                   // rearm
        repeat (2) @(posedge MCLK);
    endtask

    // flash model, mode 0 style, sees last cycle's pins
    always @(posedge MCLK)
    begin
        if (ncs !== 1'b0)
            rx_cnt = 0;                    // deselected, next bits are a command
        else if (sclk && !sclk_q && rx_cnt < 32)
        begin
            rx_word = {rx_word[30:0], mosi};
            rx_cnt  = rx_cnt + 1;
            if (rx_cnt == 32)
            begin
                flash_bits = flash_stream(rx_word[23:0]);
                data_cnt   = 0;
                cmd_seen   = 1'b1;
            end
        end
        else if (!sclk && sclk_q && rx_cnt == 32)
        begin
            miso     <= (data_cnt < SW) ? flash_bits[data_cnt] : 1'b0;  // next bit on fall
            data_cnt = data_cnt + 1;
        end
        sclk_q = sclk;
    end

    always @(negedge MCLK)
    begin
        if (buf_we === 1'b1)
        begin
            buf_ref[buf_addr] = buf_data;
            wr_cnt = wr_cnt + 1;
        end
    end

    always @(negedge MCLK)
    begin
        assert (UUT.u_props.fail_cnt == 0)
        else report_failure("a bound protocol assertion failed");
    end

    initial
    begin
        longint limit;
        wait (stim_loaded);
        limit = longint'(n_lines) * (BOOT_BITS + MAP_BITS + 2 * MAP_BITS) * 4 * CLK_P
                + 20 * CLK_P;              // plus reset
        #(limit);
        report_failure($sformatf("watchdog expired after %0d ns", limit));
    end

    initial
    begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_acc;
        logic [31:0] f_img;
        logic [31:0] f_page;
        logic [31:0] f_addr;
        fd = $fopen("test/loader_stim.txt", "r");
        assert (fd != 0) else report_failure("cannot open test/loader_stim.txt");
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#")
            begin
                n = $sscanf(line, "%h %h %h %h", f_acc, f_img, f_page, f_addr);
                if (n == 4)
                begin
                    q_acc.push_back(f_acc[1:0]);
                    q_img.push_back(f_img[2:0]);
                    q_page.push_back(f_page[11:0]);
                    q_addr.push_back(f_addr[23:0]);
                end
            end
        end
        $fclose(fd);
        n_lines = q_acc.size();
        assert (n_lines > 0) else report_failure("stimulus file holds no accesses");
        stim_loaded = 1'b1;
        repeat (2) @(posedge MCLK);
        rst_n <= 1'b1;
        repeat (2) @(posedge MCLK);
        for (int i = 0; i < n_lines; i++)
            run_access(i);
        @(negedge MCLK);
        if (UUT.u_props.fail_cnt == 0)
            $display("TEST OK");
        else
            report_failure("a bound protocol assertion failed");
        $finish;
    end

endmodule

/* test/spi_loader_props.sv */
`timescale 1ns/1ps

module spi_loader_props
(
    input logic MCLK,
    input logic rst_n,
    input logic busy,
    input logic buf_we,
    input logic ncs,
    input logic sclk
);

    int fail_cnt = 0;   // read by the testbench

    // flash clock parks high while deselected
    sclk_idle: assert property (@(posedge MCLK) disable iff (!rst_n) ncs |-> sclk)
    else
    begin
        $error("sclk low while ncs high");
        fail_cnt = fail_cnt + 1;
    end

    we_pulse: assert property (@(posedge MCLK) disable iff (!rst_n) buf_we |=> !buf_we)
    else
    begin
        $error("buf_we held longer than one cycle");
        fail_cnt = fail_cnt + 1;
    end

    reset_idle: assert property (@(posedge MCLK) !rst_n |=> !busy && ncs && sclk && !buf_we)
    else
    begin
        $error("outputs not idle after reset");
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind spi_loader_top spi_loader_props u_props (
    .MCLK(MCLK), .rst_n(rst_n), .busy(busy), .buf_we(buf_we), .ncs(ncs), .sclk(sclk)
);

/* verilog/spi_loader_top.sv */
`timescale 1ns/1ps

module spi_loader_top
    import bubble_pkg::*;
#(
    parameter int BOOT_BITS = BOOT_BITS_D,
    parameter int MAP_BITS  = MAP_BITS_D,
    parameter int PAGE_GOOD = PAGE_GOOD_D,
    parameter int LEAD_BITS = LEAD_BITS_D
)
(
    input  logic       MCLK,
    input  logic       rst_n,
    input  logic [2:0] img,
    input  acc_kind_e  acc,
    input  page_t      page,
    output logic       busy,
    output logic       buf_we,
    output buf_addr_t  buf_addr,
    output logic       buf_data,
    output logic       ncs,
    output logic       sclk,
    output logic       mosi,
    input  logic       miso
);

    logic        cmd_start;
    flash_addr_t cmd_addr;
    logic        cmd_done;
    bit_req_t    seq_req;
    bit_req_t    page_req;
    bit_res_t    bit_res;
    logic        page_start;
    logic        page_done;
    buf_wr_t     mask_wr;

    load_sequencer #(.BOOT_BITS(BOOT_BITS), .MAP_BITS(MAP_BITS)) u_seq (
        .MCLK(MCLK), .rst_n(rst_n), .img(img), .acc(acc), .page(page),
        .cmd_start(cmd_start), .cmd_addr(cmd_addr), .seq_req(seq_req),
        .page_start(page_start), .busy(busy), .cmd_done(cmd_done),
        .bit_res(bit_res), .page_done(page_done)
    );

    spi_bit_engine u_spi (
        .MCLK(MCLK), .rst_n(rst_n), .cmd_start(cmd_start), .cmd_addr(cmd_addr),
        .seq_req(seq_req), .page_req(page_req), .cmd_done(cmd_done),
        .bit_res(bit_res), .ncs(ncs), .sclk(sclk), .mosi(mosi), .miso(miso),
        .busy(busy)
    );

    loop_mask_table #(.PAGE_GOOD(PAGE_GOOD), .LEAD_BITS(LEAD_BITS)) u_mask (
        .MCLK(MCLK), .rst_n(rst_n), .bit_res(bit_res), .page_start(page_start),
        .page_req(page_req), .mask_wr(mask_wr), .page_done(page_done)
    );

    outbuf_writer u_wr (
        .MCLK(MCLK), .rst_n(rst_n), .bit_res(bit_res), .mask_wr(mask_wr),
        .buf_we(buf_we), .buf_addr(buf_addr), .buf_data(buf_data)
    );

endmodule

/* verilog/outbuf_writer.sv */
`timescale 1ns/1ps

module outbuf_writer
    import bubble_pkg::*;
(
    input  logic      MCLK,
    input  logic      rst_n,
    input  bit_res_t  bit_res,
    input  buf_wr_t   mask_wr,
    output logic      buf_we,
    output buf_addr_t buf_addr,
    output logic      buf_data
);

    buf_addr_t ptr;         // next free address
    buf_addr_t cur;         // address for this cycle's write
    logic      boot_run;    // inside a boot stream
    logic      load_boot;
    logic      wr_any;

    assign load_boot = bit_res.valid && bit_res.kind == bk_boot && !boot_run;
    assign wr_any    = bit_res.valid | mask_wr.valid;
    assign cur = mask_wr.start ? (mask_wr.base ? PAGE_BASE : BOOT_BASE) :
                 load_boot     ? BOOT_BASE : ptr;

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            buf_we   <= 1'b0;
            boot_run <= 1'b0;
            ptr      <= '0;
        end
        else
        begin
            buf_we <= wr_any;           // one cycle after the strobe
            if (bit_res.valid)
                boot_run <= bit_res.kind == bk_boot;
            if (wr_any)
                ptr <= cur + 1'b1;
            else if (mask_wr.start)
                ptr <= cur;             // page opens with a flash bit
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (wr_any)
        begin
            buf_addr <= cur;
            buf_data <= bit_res.valid ? bit_res.data : mask_wr.data;
        end
    end

endmodule

/* mask/loop_mask_table.sv */
`timescale 1ns/1ps

module loop_mask_table
    import bubble_pkg::*;
#(
    parameter int PAGE_GOOD = PAGE_GOOD_D,
    parameter int LEAD_BITS = LEAD_BITS_D
)
(
    input  logic     MCLK,
    input  logic     rst_n,
    input  bit_res_t bit_res,
    input  logic     page_start,
    output bit_req_t page_req,
    output buf_wr_t  mask_wr,
    output logic     page_done
);

    localparam int GW = $clog2(PAGE_GOOD + 1);
    localparam int LW = $clog2(LEAD_BITS + 2);

    typedef enum logic [1:0] {ph_idle, ph_read, ph_dec, ph_wait} walk_e;

    logic            map_mem [0:4095];  // 1 = good loop
    map_addr_t       wr_ptr;
    map_addr_t       map_wa;
    logic            map_we;
    logic            after_boot;        // last flash result was a boot bit
    map_addr_t       rd_ptr;
    logic            rd_q;
    walk_e           ph;
    logic [GW-1:0]   good_cnt;
    logic [LW-1:0]   lead_cnt;
    logic            first;             // next slot opens the page
    logic            last_good;

    assign map_we    = bit_res.valid && bit_res.kind == bk_map;
    assign map_wa    = after_boot ? '0 : wr_ptr;      // restart per boot access
    assign last_good = good_cnt == GW'(PAGE_GOOD - 1);

    always_ff @(posedge MCLK)
    begin
        if (map_we)
            map_mem[{map_wa[11:4], ~map_wa[3:0]}] <= bit_res.data;  // low nibble inverted
        rd_q <= map_mem[rd_ptr];
    end

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            wr_ptr     <= '0;
            after_boot <= 1'b0;
            rd_ptr     <= '0;
            ph         <= ph_idle;
            good_cnt   <= '0;
            lead_cnt   <= '0;
            first      <= 1'b0;
            page_req   <= '0;
            mask_wr    <= '0;
            page_done  <= 1'b0;
        end
        else
        begin
            page_req.valid <= 1'b0;
            mask_wr.valid  <= 1'b0;
            mask_wr.start  <= 1'b0;
            page_done      <= 1'b0;
            if (bit_res.valid)
                after_boot <= bit_res.kind == bk_boot;
            if (map_we)
                wr_ptr <= map_wa + 1'b1;
            case (ph)
                ph_idle:
                begin
                    if (page_start)
                    begin
                        rd_ptr   <= '0;
                        good_cnt <= '0;
                        lead_cnt <= '0;
                        first    <= 1'b1;
                        ph       <= ph_read;
                    end
                end
                ph_read:
                begin
                    rd_ptr <= rd_ptr + 1'b1;   // rd_q valid next cycle
                    ph     <= ph_dec;
                end
                ph_dec:
                begin
                    first         <= 1'b0;
                    mask_wr.start <= first;
                    mask_wr.base  <= 1'b1;
                    if (!rd_q)
                    begin
                        mask_wr.valid <= 1'b1; // bad loop reads as 0
                        mask_wr.data  <= 1'b0;
                        ph            <= ph_read;
                    end
                    else if (lead_cnt < LW'(LEAD_BITS))
                    begin
                        mask_wr.valid <= 1'b1; // lead loop, no flash clock
                        mask_wr.data  <= 1'b1;
                        lead_cnt      <= lead_cnt + 1'b1;
                        good_cnt      <= good_cnt + 1'b1;
                        page_done     <= last_good;
                        ph            <= last_good ? ph_idle : ph_read;
                    end
                    else
                    begin
                        page_req <= '{valid: 1'b1, kind: bk_page};
                        ph       <= ph_wait;
                    end
                end
                default:
                begin
                    if (bit_res.valid && bit_res.kind == bk_page)
                    begin
                        good_cnt  <= good_cnt + 1'b1;
                        page_done <= last_good;
                        ph        <= last_good ? ph_idle : ph_read;
                    end
                end
            endcase
        end
    end

endmodule

/* spi/spi_bit_engine.sv */
`timescale 1ns/1ps

module spi_bit_engine
    import bubble_pkg::*;
(
    input  logic        MCLK,
    input  logic        rst_n,
    input  logic        cmd_start,
    input  flash_addr_t cmd_addr,
    input  bit_req_t    seq_req,
    input  bit_req_t    page_req,
    output logic        cmd_done,
    output bit_res_t    bit_res,
    output logic        ncs,
    output logic        sclk,
    output logic        mosi,
    input  logic        miso,
    input  logic        busy
);

    logic [31:0] shift;     // opcode + address, msb first
    logic [4:0]  cmd_cnt;
    logic        cmd_act;
    logic        ncs_q;
    logic        bit_low;   // data bit, sclk low phase
    logic        bit_high;  // data bit, sclk high phase
    bit_kind_e   kind_q;
    logic        req_any;
    bit_kind_e   req_kind;

    assign req_any  = seq_req.valid | page_req.valid;    // never both at once
    assign req_kind = seq_req.valid ? seq_req.kind : page_req.kind;
    assign mosi     = shift[31];
    assign ncs      = ncs_q | ~busy;   // release with busy, same cycle

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            ncs_q    <= 1'b1;
            sclk     <= 1'b1;          // idle high
            cmd_act  <= 1'b0;
            cmd_cnt  <= '0;
            cmd_done <= 1'b0;
            bit_low  <= 1'b0;
            bit_high <= 1'b0;
            bit_res.valid <= 1'b0;
        end
        else
        begin
            cmd_done      <= 1'b0;
            bit_res.valid <= 1'b0;
            if (cmd_start)
            begin
                ncs_q   <= 1'b0;
                sclk    <= 1'b0;       // first low phase with bit 31 on mosi
                cmd_act <= 1'b1;
                cmd_cnt <= '0;
            end
            else if (!busy)
                ncs_q <= 1'b1;
            if (cmd_act)
            begin
                if (!sclk)
                    sclk <= 1'b1;      // flash samples here
                else
                begin
                    cmd_cnt <= cmd_cnt + 1'b1;
                    if (cmd_cnt == 5'd31)
                    begin
                        cmd_act  <= 1'b0;
                        cmd_done <= 1'b1;
                    end
                    else
                        sclk <= 1'b0;
                end
            end
            if (req_any)
            begin
                sclk    <= 1'b0;
                bit_low <= 1'b1;
            end
            if (bit_low)
            begin
                sclk     <= 1'b1;
                bit_low  <= 1'b0;
                bit_high <= 1'b1;
            end
            if (bit_high)
            begin
                bit_high      <= 1'b0;
                bit_res.valid <= 1'b1;  // third cycle after request
            end
        end
    end

    // payload side, no reset
    always_ff @(posedge MCLK)
    begin
        if (cmd_start)
            shift <= {OPC_READ, cmd_addr};
        else if (cmd_act && sclk)
            shift <= shift << 1;       // next bit for next low phase
        if (req_any)
            kind_q <= req_kind;
        if (bit_high)
        begin
            bit_res.data <= miso;      // sampled at end of high phase
            bit_res.kind <= kind_q;
        end
    end

endmodule

/* verilog/load_sequencer.sv */
`timescale 1ns/1ps

module load_sequencer
    import bubble_pkg::*;
#(
    parameter int BOOT_BITS = BOOT_BITS_D,
    parameter int MAP_BITS  = MAP_BITS_D
)
(
    input  logic        MCLK,
    input  logic        rst_n,
    input  logic [2:0]  img,
    input  acc_kind_e   acc,
    input  page_t       page,
    output logic        cmd_start,
    output flash_addr_t cmd_addr,
    output bit_req_t    seq_req,
    output logic        page_start,
    output logic        busy,
    input  logic        cmd_done,
    input  bit_res_t    bit_res,
    input  logic        page_done
);

    // wide enough for the longer of the two regions
    localparam int CW = $clog2(BOOT_BITS > MAP_BITS ? BOOT_BITS : MAP_BITS) + 1;

    seq_state_e      state;
    acc_kind_e       kind_q;    // access latched at arm time
    logic [CW-1:0]   cnt;       // results seen in current region

    // busy covers command through last result
    assign busy = (state == st_cmd) || (state == st_boot) ||
                  (state == st_map) || (state == st_page);

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            state      <= st_wait;     // need acc none before first arm
            kind_q     <= acc_none;
            cnt        <= '0;
            cmd_start  <= 1'b0;
            seq_req    <= '0;
            page_start <= 1'b0;
        end
        else
        begin
            cmd_start     <= 1'b0;     // strobes by default
            seq_req.valid <= 1'b0;
            page_start    <= 1'b0;
            case (state)
                st_wait:
                begin
                    if (acc == acc_none)
                        state <= st_idle;
                end
                st_idle:
                begin
                    if (acc != acc_none)
                    begin
                        kind_q    <= acc;
                        cmd_start <= 1'b1;
                        state     <= st_cmd;
                    end
                end
                st_cmd:
                begin
                    cnt <= '0;
                    if (cmd_done)
                    begin
                        if (kind_q == acc_boot)
                        begin
                            seq_req <= '{valid: 1'b1, kind: bk_boot};  // first boot bit
                            state   <= st_boot;
                        end
                        else
                        begin
                            page_start <= 1'b1;    // hand over to mask stage
                            state      <= st_page;
                        end
                    end
                end
                st_boot:
                begin
                    if (bit_res.valid && bit_res.kind == bk_boot)
                    begin
                        if (cnt == CW'(BOOT_BITS - 1))
                        begin
                            cnt     <= '0;
                            seq_req <= '{valid: 1'b1, kind: bk_map};   // map follows directly
                            state   <= st_map;
                        end
                        else
                        begin
                            cnt     <= cnt + 1'b1;
                            seq_req <= '{valid: 1'b1, kind: bk_boot};
                        end
                    end
                end
                st_map:
                begin
                    if (bit_res.valid && bit_res.kind == bk_map)
                    begin
                        if (cnt == CW'(MAP_BITS - 1))
                            state <= st_done;
                        else
                        begin
                            cnt     <= cnt + 1'b1;
                            seq_req <= '{valid: 1'b1, kind: bk_map};
                        end
                    end
                end
                st_page:
                begin
                    if (page_done)
                        state <= st_done;
                end
                default:
                    state <= st_wait;      // st_done, drop busy for one pass
            endcase
        end
    end

    // image, page and zero byte offset within page
    always_ff @(posedge MCLK)
    begin
        if (state == st_idle && acc != acc_none)
            cmd_addr <= {2'b00, img, (acc == acc_boot) ? BOOT_PAGE : page, 7'b000_0000};
    end

endmodule

/* common/bubble_pkg.sv */
package bubble_pkg;

    // emulator access bits, bit 1 = access, bit 0 = page read
    typedef enum logic [1:0] {
        acc_none = 2'b00,   // bus quiet
        acc_boot = 2'b10,   // bootloader + loop map
        acc_page = 2'b11    // one page through the map
    } acc_kind_e;

    typedef enum logic [2:0] {
        st_idle,            // armed, waiting for an access
        st_wait,            // waiting for acc to drop back to none
        st_cmd,             // read command on the wire
        st_boot,            // bootloader bits
        st_map,             // bad-loop map bits
        st_page,            // mask stage owns the walk
        st_done             // release flash, back to wait
    } seq_state_e;

    typedef enum logic [1:0] {
        bk_boot,            // goes to buffer only
        bk_map,             // buffer and map table
        bk_page             // good loop of a page
    } bit_kind_e;

    typedef struct packed {
        logic      valid;   // one-cycle strobe
        bit_kind_e kind;
    } bit_req_t;

    typedef struct packed {
        logic      valid;   // one-cycle strobe
        logic      data;    // miso sample
        bit_kind_e kind;    // copied from request
    } bit_res_t;

    typedef struct packed {
        logic valid;        // write strobe
        logic data;
        logic start;        // reload address from base
        logic base;         // 0 = boot base, 1 = page base
    } buf_wr_t;

    typedef logic [23:0] flash_addr_t;
    typedef logic [11:0] page_t;
    typedef logic [14:0] buf_addr_t;
    typedef logic [11:0] map_addr_t;

    localparam logic [7:0] OPC_READ  = 8'h03;
    localparam page_t      BOOT_PAGE = 12'h805;
    localparam buf_addr_t  BOOT_BASE = 15'd4106;
    localparam buf_addr_t  PAGE_BASE = 15'd14336;

    // full-size image regions
    localparam int BOOT_BITS_D = 2656;
    localparam int MAP_BITS_D  = 1200;
    localparam int PAGE_GOOD_D = 1030;
    localparam int LEAD_BITS_D = 6;

endpackage
